// File: Makefile
TOOL     = verilator
TOP      = tb_seq_top
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
RUNARGS  = +verilator+error+limit+100
PASS_MSG = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNARGS) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: include/seq_settings.svh
////////////////////////////////////////
// Sizing of the vector sequencer, shared by the RTL and the testbench
// Include this file before any use of the SEQ_ macros
////////////////////////////////////////

`ifndef SEQ_SETTINGS_SVH
`define SEQ_SETTINGS_SVH

// Instructions that may be in flight at once, one ID each
`define SEQ_NR_VINSN 8

// Architectural vector registers
`define SEQ_NR_VREGS 32

// Functional units: ALU, multiplier, load and store
`define SEQ_NR_VFUS 4

// Register that holds the mask of a masked instruction
`define SEQ_MASK_VREG 0

// Instruction queue depth of each unit
`define SEQ_ALU_DEPTH 2
`define SEQ_MUL_DEPTH 2
`define SEQ_LOAD_DEPTH 2
`define SEQ_STORE_DEPTH 2

`endif

// File: rtl/insn_queue_counters.sv
////////////////////////////////////////
// Instruction queue occupancy of each unit, stalls issue to a full unit
////////////////////////////////////////

`timescale 1ns/1ps

`include "seq_settings.svh"

module insn_queue_counters (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    issue_i,
  input  seq_pkg::vfu_e           issue_vfu_i,
  input  seq_pkg::vfu_done_t      done_i,
  output logic [`SEQ_NR_VFUS-1:0] vfu_ready_o
);

  import seq_pkg::*;

  // Queue depth of each unit, in vfu_e order
  localparam int unsigned InsnQueueDepth [`SEQ_NR_VFUS] = '{
    `SEQ_ALU_DEPTH,
    `SEQ_MUL_DEPTH,
    `SEQ_LOAD_DEPTH,
    `SEQ_STORE_DEPTH
  };

  for (genvar u = 0; u < `SEQ_NR_VFUS; u++) begin : gen_cnt
    cnt_t cnt_q;
    logic cnt_up;
    logic cnt_down;

    // Counting happens at issue, so the count never passes the depth
    assign cnt_up   = issue_i && (issue_vfu_i == vfu_e'(u));
    // A unit retires at most one instruction per cycle
    assign cnt_down = |vfu_done_mask(done_i, vfu_e'(u));

    // Issue and retire in the same cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt_ff
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end

    // Room left in this unit's queue
    assign vfu_ready_o[u] = cnt_q < cnt_t'(InsnQueueDepth[u]);
  end

endmodule

// File: rtl/issue_ctrl.sv
////////////////////////////////////////
// Decides whether the current request may issue and drives the
// registered one-cycle request strobe to the units
////////////////////////////////////////

`timescale 1ns/1ps

`include "seq_settings.svh"

module issue_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  seq_pkg::seq_req_t       req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  seq_pkg::hazard_t        hazard_i,
  input  seq_pkg::vid_t           next_id_i,
  input  logic                    full_i,
  input  logic [`SEQ_NR_VFUS-1:0] vfu_ready_i,
  output logic                    issue_o,
  output seq_pkg::vid_t           issue_id_o,
  output seq_pkg::vfu_e           issue_vfu_o,
  output seq_pkg::pe_req_t        pe_req_o,
  output logic                    pe_req_valid_o
);

  import seq_pkg::*;

  pe_req_t    pe_req_d;
  insn_mask_t issue_mask;
  logic       no_vrf_src;

  // Unit that executes an operation
  function automatic vfu_e op_to_vfu(seq_op_e op);
    case (op)
      OP_ADD, OP_AND:  return VFU_ALU;
      OP_MUL, OP_MACC: return VFU_MUL;
      OP_LOAD:         return VFU_LOAD;
      default:         return VFU_STORE;
    endcase
  endfunction

  assign issue_vfu_o = op_to_vfu(req_i.op);
  assign issue_id_o  = next_id_i;

  ////////////////////////////////////////
  // Stall decision

  // No vector source and no mask, so nothing would hold it back in the units
  assign no_vrf_src = !req_i.use_vs1 && !req_i.use_vs2 && req_i.vm;

  // Such an instruction only leaves once all of its hazards are gone
  assign req_ready_o = !full_i && vfu_ready_i[issue_vfu_o] && !(no_vrf_src && |hazard_i);
  assign issue_o     = req_valid_i && req_ready_o;

  ////////////////////////////////////////
  // Unit request

  // Drops a stale dependency on the ID that is being handed out again
  assign issue_mask = insn_mask_t'(1) << next_id_i;

  always_comb begin : p_pe_req
    pe_req_d               = '0;
    pe_req_d.id            = next_id_i;
    pe_req_d.vfu           = issue_vfu_o;
    pe_req_d.op            = req_i.op;
    pe_req_d.vd            = req_i.vd;
    pe_req_d.vs1           = req_i.vs1;
    pe_req_d.vs2           = req_i.vs2;
    pe_req_d.use_vd        = req_i.use_vd;
    pe_req_d.use_vs1       = req_i.use_vs1;
    pe_req_d.use_vs2       = req_i.use_vs2;
    pe_req_d.vm            = req_i.vm;
    pe_req_d.hazard.hz_vs1 = hazard_i.hz_vs1 & ~issue_mask;
    pe_req_d.hazard.hz_vs2 = hazard_i.hz_vs2 & ~issue_mask;
    pe_req_d.hazard.hz_vm  = hazard_i.hz_vm & ~issue_mask;
    pe_req_d.hazard.hz_vd  = hazard_i.hz_vd & ~issue_mask;
  end

  // Strobe is high for exactly the cycle after acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid_ff
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else begin
      pe_req_valid_o <= issue_o;
    end
  end

  always_ff @(posedge clk_i) begin : p_pe_req_ff
    if (issue_o) begin
      pe_req_o <= pe_req_d;
    end
  end

endmodule

// File: rtl/seq_pkg.sv
////////////////////////////////////////
// Types shared by the sequencer blocks and by the testbench
////////////////////////////////////////

`include "seq_settings.svh"

package seq_pkg;

  // Instruction ID and register index
  typedef logic [$clog2(`SEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(`SEQ_NR_VREGS)-1:0] vreg_t;

  // One bit per instruction ID
  typedef logic [`SEQ_NR_VINSN-1:0] insn_mask_t;

  // Operations understood by the sequencer
  typedef enum logic [2:0] {
    OP_ADD,
    OP_AND,
    OP_MUL,
    OP_MACC,
    OP_LOAD,
    OP_STORE
  } seq_op_e;

  // Functional units, the encoding doubles as the unit index
  typedef enum logic [1:0] {
    VFU_ALU,
    VFU_MUL,
    VFU_LOAD,
    VFU_STORE
  } vfu_e;

  // Request from the dispatcher. vm high means unmasked
  typedef struct packed {
    seq_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    logic    use_vd;
    logic    use_vs1;
    logic    use_vs2;
    logic    vm;
  } seq_req_t;

  // IDs that each operand of an instruction has to wait for
  typedef struct packed {
    insn_mask_t hz_vs1;
    insn_mask_t hz_vs2;
    insn_mask_t hz_vm;
    insn_mask_t hz_vd;
  } hazard_t;

  // Request strobed to the functional units
  typedef struct packed {
    vid_t    id;
    vfu_e    vfu;
    seq_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    logic    use_vd;
    logic    use_vs1;
    logic    use_vs2;
    logic    vm;
    hazard_t hazard;
  } pe_req_t;

  // Completion pulses, one ID mask per unit. Field order follows vfu_e
  typedef struct packed {
    insn_mask_t store_done;
    insn_mask_t load_done;
    insn_mask_t mul_done;
    insn_mask_t alu_done;
  } vfu_done_t;

  // Queue occupancy, wide enough for a depth of up to 3
  typedef logic [1:0] cnt_t;

  // Picks the completion mask of one unit
  function automatic insn_mask_t vfu_done_mask(vfu_done_t done, vfu_e vfu);
    case (vfu)
      VFU_ALU:   return done.alu_done;
      VFU_MUL:   return done.mul_done;
      VFU_LOAD:  return done.load_done;
      default:   return done.store_done;
    endcase
  endfunction

endpackage

// File: rtl/seq_top.sv
////////////////////////////////////////
// Vector instruction sequencer top level
// Takes dispatcher requests and strobes them to the units with hazards
////////////////////////////////////////

`timescale 1ns/1ps

`include "seq_settings.svh"

module seq_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Dispatcher side
  input  seq_pkg::seq_req_t                         req_i,
  input  logic                                      req_valid_i,
  output logic                                      req_ready_o,
  // Functional unit side
  output seq_pkg::pe_req_t                          pe_req_o,
  output logic                                      pe_req_valid_o,
  input  seq_pkg::vfu_done_t                        done_i,
  // Operand requester side, one row per instruction ID
  output seq_pkg::insn_mask_t [`SEQ_NR_VINSN-1:0]   hazard_table_o,
  output logic                                      idle_o
);

  import seq_pkg::*;

  // Issue of the current request, shared by all blocks
  logic                    issue;
  vid_t                    issue_id;
  vfu_e                    issue_vfu;

  // Status returned to the issue logic
  vid_t                    next_id;
  logic                    full;
  insn_mask_t              running;
  hazard_t                 hazard;
  logic [`SEQ_NR_VFUS-1:0] vfu_ready;

  vinsn_tracker i_vinsn_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue),
    .issue_id_i  (issue_id),
    .issue_vfu_i (issue_vfu),
    .done_i      (done_i),
    .next_id_o   (next_id),
    .full_o      (full),
    .running_o   (running),
    .idle_o      (idle_o)
  );

  vreg_scoreboard i_vreg_scoreboard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .issue_i        (issue),
    .issue_id_i     (issue_id),
    .running_i      (running),
    .hazard_o       (hazard),
    .hazard_table_o (hazard_table_o)
  );

  insn_queue_counters i_insn_queue_counters (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue),
    .issue_vfu_i (issue_vfu),
    .done_i      (done_i),
    .vfu_ready_o (vfu_ready)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .hazard_i       (hazard),
    .next_id_i      (next_id),
    .full_i         (full),
    .vfu_ready_i    (vfu_ready),
    .issue_o        (issue),
    .issue_id_o     (issue_id),
    .issue_vfu_o    (issue_vfu),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o)
  );

endmodule

// File: rtl/vinsn_tracker.sv
////////////////////////////////////////
// Tracks which instruction IDs run on which unit
// Hands out the lowest free ID and flags idle
////////////////////////////////////////

`timescale 1ns/1ps

`include "seq_settings.svh"

module vinsn_tracker (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_i,
  input  seq_pkg::vid_t       issue_id_i,
  input  seq_pkg::vfu_e       issue_vfu_i,
  input  seq_pkg::vfu_done_t  done_i,
  output seq_pkg::vid_t       next_id_o,
  output logic                full_o,
  output seq_pkg::insn_mask_t running_o,
  output logic                idle_o
);

  import seq_pkg::*;

  // Bit i of entry u is set while instruction i runs on unit u
  insn_mask_t [`SEQ_NR_VFUS-1:0] unit_running_d, unit_running_q;

  ////////////////////////////////////////
  // Per-unit running masks

  always_comb begin : p_unit_running
    for (int u = 0; u < `SEQ_NR_VFUS; u++) begin
      // A unit only retires the IDs it was given
      unit_running_d[u] = unit_running_q[u] & ~vfu_done_mask(done_i, vfu_e'(u));
      if (issue_i && (issue_vfu_i == vfu_e'(u))) begin
        unit_running_d[u][issue_id_i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_unit_running_ff
    if (!rst_ni) begin
      unit_running_q <= '0;
    end else begin
      unit_running_q <= unit_running_d;
    end
  end

  ////////////////////////////////////////
  // Global view and free-ID search

  always_comb begin : p_global_running
    running_o = '0;
    for (int u = 0; u < `SEQ_NR_VFUS; u++) begin
      running_o |= unit_running_q[u];
    end
  end

  // Scan from the top so that the lowest free ID is the last one written
  always_comb begin : p_free_id
    next_id_o = '0;
    full_o    = 1'b1;
    for (int i = `SEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = vid_t'(i);
        full_o    = 1'b0;
      end
    end
  end

  // Nothing in flight anywhere
  assign idle_o = ~|running_o;

endmodule

// File: rtl/vreg_scoreboard.sv
////////////////////////////////////////
// Per-register reader and writer lists, hazard checks of the current request
// and the global hazard table read by the operand requesters
////////////////////////////////////////

`timescale 1ns/1ps

`include "seq_settings.svh"

module vreg_scoreboard (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  seq_pkg::seq_req_t                       req_i,
  input  logic                                    issue_i,
  input  seq_pkg::vid_t                           issue_id_i,
  input  seq_pkg::insn_mask_t                     running_i,
  output seq_pkg::hazard_t                        hazard_o,
  output seq_pkg::insn_mask_t [`SEQ_NR_VINSN-1:0] hazard_table_o
);

  import seq_pkg::*;

  // Last instruction that touched a register, and whether it still counts
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [`SEQ_NR_VREGS-1:0] read_list_d, read_list_q;
  vreg_access_t [`SEQ_NR_VREGS-1:0] write_list_d, write_list_q;

  insn_mask_t [`SEQ_NR_VINSN-1:0] hazard_table_d;
  insn_mask_t                     war_mask;
  insn_mask_t                     issue_mask;

  // Turns a list entry into an ID mask, empty when the entry is stale
  function automatic insn_mask_t access_mask(vreg_access_t acc);
    return acc.valid ? (insn_mask_t'(1) << acc.vid) : '0;
  endfunction

  ////////////////////////////////////////
  // Hazards of the current request

  // The last reader of vd blocks every operand of the new writer
  assign war_mask = req_i.use_vd ? access_mask(read_list_q[req_i.vd]) : '0;

  always_comb begin : p_hazard
    hazard_o = '0;
    // RAW on each source, including the mask register of masked instructions
    if (req_i.use_vs1) hazard_o.hz_vs1 = access_mask(write_list_q[req_i.vs1]);
    if (req_i.use_vs2) hazard_o.hz_vs2 = access_mask(write_list_q[req_i.vs2]);
    if (!req_i.vm) hazard_o.hz_vm = access_mask(write_list_q[`SEQ_MASK_VREG]);
    // WAR
    hazard_o.hz_vs1 |= war_mask;
    hazard_o.hz_vs2 |= war_mask;
    hazard_o.hz_vm  |= war_mask;
    // WAW
    if (req_i.use_vd) hazard_o.hz_vd = access_mask(write_list_q[req_i.vd]);
  end

  ////////////////////////////////////////
  // Reader and writer lists

  always_comb begin : p_lists
    read_list_d  = read_list_q;
    write_list_d = write_list_q;

    // Entries of retired IDs stop counting one cycle after the running bit drops
    for (int v = 0; v < `SEQ_NR_VREGS; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end

    // The new instruction becomes the last writer and reader of its registers
    if (issue_i) begin
      if (req_i.use_vd) write_list_d[req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs1) read_list_d[req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs2) read_list_d[req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      if (!req_i.vm) read_list_d[`SEQ_MASK_VREG] = '{vid: issue_id_i, valid: 1'b1};
    end
  end

  ////////////////////////////////////////
  // Global hazard table

  // A stale entry may still name the ID being reused, which must not wait on itself
  assign issue_mask = insn_mask_t'(1) << issue_id_i;

  always_comb begin : p_table
    // Row N lists the IDs that instruction N waits for
    for (int id = 0; id < `SEQ_NR_VINSN; id++) begin
      hazard_table_d[id] = hazard_table_o[id] & running_i;
    end
    if (issue_i) begin
      hazard_table_d[issue_id_i] = (hazard_o.hz_vs1 | hazard_o.hz_vs2 |
                                    hazard_o.hz_vm | hazard_o.hz_vd) & ~issue_mask;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_ff
    if (!rst_ni) begin
      read_list_q    <= '0;
      write_list_q   <= '0;
      hazard_table_o <= '0;
    end else begin
      read_list_q    <= read_list_d;
      write_list_q   <= write_list_d;
      hazard_table_o <= hazard_table_d;
    end
  end

endmodule

// File: verif/seq_top_sva.sv
////////////////////////////////////////
// Concurrent checks on the sequencer top level, bound into seq_top
////////////////////////////////////////

`timescale 1ns/1ps

`include "seq_settings.svh"

module seq_top_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                req_valid_i,
  input logic                req_ready_i,
  input logic                pe_req_valid_i,
  input seq_pkg::pe_req_t    pe_req_i,
  input logic                issue_i,
  input seq_pkg::vid_t       issue_id_i,
  input seq_pkg::insn_mask_t running_i
);

  import seq_pkg::*;

  // Failures seen so far, read by the testbench at the end of the run
  int fail_count = 0;

  // Every acceptance gives a strobe in the next cycle, and nothing else does
  a_strobe_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && req_ready_i) |=> pe_req_valid_i)
    else begin
      $error("Strobe missing after an accepted request");
      fail_count++;
    end

  a_no_stray_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_valid_i && req_ready_i) |=> !pe_req_valid_i)
    else begin
      $error("Strobe without an accepted request");
      fail_count++;
    end

  // A handed-out ID is never one that is still running
  a_id_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_i |-> !running_i[issue_id_i])
    else begin
      $error("ID issued while still running");
      fail_count++;
    end

  // The tracker marks the strobed ID as running by the time the units see it
  a_strobe_running: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i |-> running_i[pe_req_i.id])
    else begin
      $error("Strobed ID is not marked as running");
      fail_count++;
    end

endmodule

bind seq_top seq_top_sva i_seq_top_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_valid_i    (req_valid_i),
  .req_ready_i    (req_ready_o),
  .pe_req_valid_i (pe_req_valid_o),
  .pe_req_i       (pe_req_o),
  .issue_i        (issue),
  .issue_id_i     (issue_id),
  .running_i      (running)
);

// File: verif/tb_seq_top.sv
////////////////////////////////////////
// Directed and random testbench for the vector sequencer
// Keeps its own model of running IDs, queue counts and register writers
////////////////////////////////////////

`timescale 1ns/1ps

`include "seq_settings.svh"

module tb_seq_top;

  import seq_pkg::*;

  // Rough length of all tests in cycles, the run is cut off at four times that
  localparam int TestCycles    = 150;
  localparam int TimeoutCycles = 4 * TestCycles;

  logic                                  clk_i = 1'b0;
  logic                                  rst_ni;
  seq_req_t                              req_i;
  logic                                  req_valid_i;
  logic                                  req_ready_o;
  pe_req_t                               pe_req_o;
  logic                                  pe_req_valid_o;
  vfu_done_t                             done_i;
  insn_mask_t [`SEQ_NR_VINSN-1:0]        hazard_table_o;
  logic                                  idle_o;

  // Reference model
  insn_mask_t m_running;
  vfu_e       m_unit [`SEQ_NR_VINSN];
  int         m_cnt [`SEQ_NR_VFUS];
  int         m_writer [`SEQ_NR_VREGS];

  string test_name;
  int    seed = 32'h46a;
  int    cycles = 0;
  int    checks = 0;
  int    errors = 0;
  int    test_errors = 0;
  int    tests = 0;
  int    last_id;
  int    exp_raw;
  int    exp_waw;
  int    idle_at_done;
  int    ready_at_done;

  seq_top i_seq_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o),
    .done_i         (done_i),
    .hazard_table_o (hazard_table_o),
    .idle_o         (idle_o)
  );

  always #10 clk_i = ~clk_i;

  // Stops a run that hangs on a stalled request
  always @(posedge clk_i) begin : p_timeout
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Checks and model helpers

  task automatic check_value(input string what, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("ERROR %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests++;
  endtask

  task automatic finish_test();
    $display("Test %s finished with %0d errors", test_name, test_errors);
  endtask

  // Lowest ID that the model does not see running
  function automatic int lowest_free();
    for (int i = 0; i < `SEQ_NR_VINSN; i++) begin
      if (!m_running[i]) return i;
    end
    return -1;
  endfunction

  // ALU ops, multiplies, loads and stores each have their own unit
  function automatic vfu_e expected_unit(seq_op_e op);
    if (op == OP_ADD || op == OP_AND) return VFU_ALU;
    if (op == OP_MUL || op == OP_MACC) return VFU_MUL;
    if (op == OP_LOAD) return VFU_LOAD;
    return VFU_STORE;
  endfunction

  function automatic seq_req_t make_req(seq_op_e op, int vd, int vs1, int vs2,
                                        logic use_vd, logic use_vs1, logic use_vs2,
                                        logic vm);
    seq_req_t r;
    r.op      = op;
    r.vd      = vreg_t'(vd);
    r.vs1     = vreg_t'(vs1);
    r.vs2     = vreg_t'(vs2);
    r.use_vd  = use_vd;
    r.use_vs1 = use_vs1;
    r.use_vs2 = use_vs2;
    r.vm      = vm;
    return r;
  endfunction

  // Called at a falling edge where ready is high and valid is held
  task automatic accept_and_check(input seq_req_t r);
    int   exp_id;
    vfu_e exp_vfu;
    exp_id  = lowest_free();
    exp_vfu = expected_unit(r.op);
    // RAW on vs1 against the model's last writer
    exp_raw = (r.use_vs1 && m_writer[r.vs1] >= 0) ? (1 << m_writer[r.vs1]) : 0;
    // WAW on vd against the same writer list
    exp_waw = (r.use_vd && m_writer[r.vd] >= 0) ? (1 << m_writer[r.vd]) : 0;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    m_running[exp_id] = 1'b1;
    m_unit[exp_id] = exp_vfu;
    m_cnt[exp_vfu]++;
    if (r.use_vd) m_writer[r.vd] = exp_id;
    last_id = exp_id;
    @(negedge clk_i);
    check_value("strobe", 1, int'(pe_req_valid_o));
    check_value("id", exp_id, int'(pe_req_o.id));
    check_value("unit", int'(exp_vfu), int'(pe_req_o.vfu));
  endtask

  task automatic issue_req(input seq_req_t r);
    @(posedge clk_i);
    req_i       <= r;
    req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    accept_and_check(r);
  endtask

  // One-cycle done pulse for an ID on the unit that runs it
  task automatic retire(input int id);
    vfu_done_t d;
    d = '0;
    case (m_unit[id])
      VFU_ALU:  d.alu_done[id] = 1'b1;
      VFU_MUL:  d.mul_done[id] = 1'b1;
      VFU_LOAD: d.load_done[id] = 1'b1;
      default:  d.store_done[id] = 1'b1;
    endcase
    @(posedge clk_i);
    done_i <= d;
    @(negedge clk_i);
    idle_at_done  = int'(idle_o);
    ready_at_done = int'(req_ready_o);
    @(posedge clk_i);
    done_i <= '0;
    m_running[id] = 1'b0;
    m_cnt[m_unit[id]]--;
    for (int v = 0; v < `SEQ_NR_VREGS; v++) begin
      if (m_writer[v] == id) m_writer[v] = -1;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence

  initial begin : p_main
    seq_req_t r;
    int       a;
    int       b;
    int       c;
    int       prev;
    int       exp_ready;
    m_running = '0;
    for (int i = 0; i < `SEQ_NR_VFUS; i++) m_cnt[i] = 0;
    for (int v = 0; v < `SEQ_NR_VREGS; v++) m_writer[v] = -1;
    rst_ni      <= 1'b0;
    req_i       <= '0;
    req_valid_i <= 1'b0;
    done_i      <= '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);

    start_test("reset");
    check_value("idle", 1, int'(idle_o));
    check_value("strobe", 0, int'(pe_req_valid_o));
    check_value("ready", 1, int'(req_ready_o));
    for (int i = 0; i < `SEQ_NR_VINSN; i++) begin
      check_value("table row", 0, int'(hazard_table_o[i]));
    end
    finish_test();

    // Lowest free ID, and a freed ID handed out again
    start_test("ids_strobe");
    issue_req(make_req(OP_ADD, 2, 3, 4, 1'b1, 1'b1, 1'b1, 1'b1));
    a = last_id;
    issue_req(make_req(OP_MUL, 12, 13, 0, 1'b1, 1'b1, 1'b0, 1'b1));
    b = last_id;
    issue_req(make_req(OP_LOAD, 20, 0, 0, 1'b1, 1'b0, 1'b0, 1'b1));
    c = last_id;
    retire(b);
    issue_req(make_req(OP_STORE, 0, 21, 0, 1'b0, 1'b1, 1'b0, 1'b1));
    retire(a);
    retire(c);
    retire(last_id);
    finish_test();

    start_test("raw_waw");
    issue_req(make_req(OP_MUL, 5, 1, 0, 1'b1, 1'b1, 1'b0, 1'b1));
    b = last_id;
    issue_req(make_req(OP_ADD, 6, 5, 0, 1'b1, 1'b1, 1'b0, 1'b1));
    a = last_id;
    check_value("hz_vs1", exp_raw, int'(pe_req_o.hazard.hz_vs1));
    check_value("table row", exp_raw, int'(hazard_table_o[a]));
    // The writer's entry is gone two cycles after its done pulse
    retire(b);
    issue_req(make_req(OP_ADD, 9, 5, 0, 1'b1, 1'b1, 1'b0, 1'b1));
    check_value("hz_vs1 after done", exp_raw, int'(pe_req_o.hazard.hz_vs1));
    retire(a);
    // A second writer of v9 waits for the add that still owns it
    c = last_id;
    issue_req(make_req(OP_AND, 9, 3, 0, 1'b1, 1'b1, 1'b0, 1'b1));
    check_value("hz_vd", exp_waw, int'(pe_req_o.hazard.hz_vd));
    retire(c);
    retire(last_id);
    finish_test();

    start_test("back_pressure");
    r = make_req(OP_STORE, 0, 10, 0, 1'b0, 1'b1, 1'b0, 1'b1);
    issue_req(r);
    a = last_id;
    issue_req(r);
    b = last_id;
    // Ready is combinational on the request, so valid stays low here
    @(posedge clk_i);
    req_i <= r;
    @(negedge clk_i);
    check_value("store ready", int'(m_cnt[VFU_STORE] < `SEQ_STORE_DEPTH), int'(req_ready_o));
    issue_req(make_req(OP_ADD, 11, 14, 0, 1'b1, 1'b1, 1'b0, 1'b1));
    c = last_id;
    @(posedge clk_i);
    req_i <= r;
    exp_ready = int'(m_cnt[VFU_STORE] < `SEQ_STORE_DEPTH);
    retire(a);
    check_value("store ready at done", exp_ready, ready_at_done);
    @(negedge clk_i);
    check_value("store ready after done", int'(m_cnt[VFU_STORE] < `SEQ_STORE_DEPTH),
                int'(req_ready_o));
    retire(b);
    retire(c);
    finish_test();

    // A load with no vector source waits out the WAR on its vd
    start_test("stall_rule");
    issue_req(make_req(OP_ADD, 8, 7, 0, 1'b1, 1'b1, 1'b0, 1'b1));
    a = last_id;
    r = make_req(OP_LOAD, 7, 0, 0, 1'b1, 1'b0, 1'b0, 1'b1);
    @(posedge clk_i);
    req_i       <= r;
    req_valid_i <= 1'b1;
    @(negedge clk_i);
    check_value("load ready before done", 0, int'(req_ready_o));
    retire(a);
    check_value("load ready at done", 0, ready_at_done);
    @(negedge clk_i);
    check_value("load ready one cycle after", 0, int'(req_ready_o));
    @(negedge clk_i);
    check_value("load ready two cycles after", 1, int'(req_ready_o));
    accept_and_check(r);
    retire(last_id);
    finish_test();

    // Each new instruction retires the previous one, so idle stays low
    start_test("idle_random");
    prev = -1;
    for (int i = 0; i < 6; i++) begin
      c = $unsigned($random(seed)) % 6;
      a = $random(seed);
      b = $random(seed);
      issue_req(make_req(seq_op_e'(c), a, b, 0, 1'b1, 1'b1, 1'b0, 1'b1));
      if (i == 0) check_value("idle after first accept", 0, int'(idle_o));
      if (prev >= 0) retire(prev);
      prev = last_id;
    end
    retire(prev);
    check_value("idle during last done", 0, idle_at_done);
    @(negedge clk_i);
    check_value("idle after last done", 1, int'(idle_o));
    finish_test();

    if (i_seq_top.i_seq_top_sva.fail_count != 0) begin
      $display("Bound assertions failed %0d times", i_seq_top.i_seq_top_sva.fail_count);
      errors++;
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
rtl/seq_pkg.sv
rtl/vinsn_tracker.sv
rtl/vreg_scoreboard.sv
rtl/insn_queue_counters.sv
rtl/issue_ctrl.sv
rtl/seq_top.sv
verif/seq_top_sva.sv
verif/tb_seq_top.sv
